/* logic/routerPkg.sv */
package routerPkg;

  localparam int NUM_PORTS = 5;
  localparam int PORT_BITS = 3;

  // Rotation order of the input ports
  localparam logic [PORT_BITS-1:0] PORT_L = 3'd0;
  localparam logic [PORT_BITS-1:0] PORT_N = 3'd1;
  localparam logic [PORT_BITS-1:0] PORT_E = 3'd2;
  localparam logic [PORT_BITS-1:0] PORT_W = 3'd3;
  localparam logic [PORT_BITS-1:0] PORT_S = 3'd4;

  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_BITS = $clog2(FIFO_DEPTH + 1);

  localparam int DATA_BITS = 16;
  localparam int LEN_BITS = 12; // Packet length in flits, header included

  localparam logic [2:0] FLIT_HEAD = 3'd1;
  localparam logic [2:0] FLIT_BODY = 3'd2;
  localparam logic [2:0] FLIT_TAIL = 3'd4;

  typedef struct packed {
    logic [2:0]           flitId;
    logic [DATA_BITS-1:0] data;
  } flitT;

  typedef logic [NUM_PORTS-1:0] grantT; // One-hot, zero when idle

endpackage

/* logic/flitHeadIf.sv */
`timescale 1ns/1ps

// Head of one input FIFO as seen by the arbiter and the switch
interface flitHeadIf import routerPkg::*; ();

  logic notEmpty;
  flitT head; // All zero while the FIFO is empty
  logic pop;

  modport bufSide (
    output notEmpty,
    output head,
    input  pop
  );

  modport arbSide (
    input  notEmpty,
    input  head,
    output pop
  );

  modport muxSide (input head);

endinterface

/* logic/flitFifo.sv */
`timescale 1ns/1ps

module flitFifo import routerPkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       inValid,
  input  flitT       inFlit,
  output logic       inFull,
  flitHeadIf.bufSide head
);

  flitT mem [FIFO_DEPTH];

  logic [FIFO_PTR_BITS-1:0] rdPtr;
  logic [FIFO_PTR_BITS-1:0] wrPtr;
  logic [FIFO_CNT_BITS-1:0] count;
  logic                     doWrite;
  logic                     doRead;

  assign doWrite = inValid;
  assign doRead = head.pop;

  assign inFull = (count == FIFO_CNT_BITS'(FIFO_DEPTH));
  assign head.notEmpty = (count != '0);
  assign head.head = head.notEmpty ? mem[rdPtr] : '0; // A zero flitId marks an empty head

  always_ff @(posedge clk)
  begin
    if (doWrite)
      mem[wrPtr] <= inFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doWrite)
        wrPtr <= (wrPtr == FIFO_PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      if (doRead)
        rdPtr <= (rdPtr == FIFO_PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      case ({doWrite, doRead})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Upstream link must respect the full level
  assert property (@(posedge clk) disable iff (rst) inValid |-> !inFull)
    else $error("flitFifo write while full");

  // The arbiter may only pop a flit that is there
  assert property (@(posedge clk) disable iff (rst) head.pop |-> head.notEmpty)
    else $error("flitFifo pop while empty");

endmodule

/* logic/wormholeArbiter.sv */
`timescale 1ns/1ps

module wormholeArbiter import routerPkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       slotFree,
  flitHeadIf.arbSide heads [NUM_PORTS],
  output grantT      grant
);

  logic [NUM_PORTS-1:0] notEmpty;
  logic [NUM_PORTS-1:0] pop;
  logic [NUM_PORTS-1:0] done;   // Forward that ends the packet
  logic [NUM_PORTS-1:0] active; // Header forwarded, tail still to come
  logic [PORT_BITS-1:0] lastPort;
  logic [PORT_BITS-1:0] grantIdx;
  logic [PORT_BITS-1:0] base;
  logic                 keep;
  grantT                nextGrant;

  for (genvar k = 0; k < NUM_PORTS; k++)
  begin : gPort
    logic                isHead;
    logic                busy;
    logic [LEN_BITS-1:0] count;
    logic [LEN_BITS-1:0] limit;
    logic [LEN_BITS-1:0] newCount;
    logic [LEN_BITS-1:0] target;

    assign notEmpty[k] = heads[k].notEmpty;
    assign isHead = (heads[k].head.flitId == FLIT_HEAD);

    // A forward is a pop
    assign pop[k] = grant[k] && notEmpty[k] && slotFree;
    assign heads[k].pop = pop[k];

    assign newCount = isHead ? LEN_BITS'(1) : count + 1'b1;
    assign target = isHead ? heads[k].head.data[LEN_BITS-1:0] : limit;
    assign done[k] = pop[k] && (newCount >= target); // A zero length acts as one
    assign active[k] = busy;

    // Packet timer counts forwarded flits, not cycles
    always_ff @(posedge clk)
    begin
      if (rst)
      begin
        count <= '0;
        limit <= '0;
        busy <= 1'b0;
      end
      else if (pop[k])
      begin
        count <= newCount;
        busy <= !done[k];
        if (isHead)
          limit <= target;
      end
    end
  end

  always_comb
  begin
    grantIdx = '0;
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      if (grant[i])
        grantIdx = PORT_BITS'(i);
    end
  end

  // Hold through the packet, even while the FIFO runs dry mid-packet
  assign keep = (|grant) && !(|done) && (|(grant & (active | notEmpty)));
  assign base = (|grant) ? grantIdx : lastPort;

  always_comb
  begin
    int idx;
    nextGrant = '0;
    // Walk from the farthest port to the nearest so the nearest one wins
    for (int i = NUM_PORTS; i >= 1; i--)
    begin
      idx = (int'(base) + i) % NUM_PORTS;
      if (notEmpty[idx])
        nextGrant = grantT'(1) << idx;
    end
    if (keep)
      nextGrant = grant;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= '0;
      lastPort <= PORT_S; // First search starts at Local
    end
    else
    begin
      grant <= nextGrant;
      if (|grant)
        lastPort <= grantIdx;
    end
  end

  assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("wormholeArbiter grant not one-hot");

  assert property (@(posedge clk) disable iff (rst) (pop & ~grant) == '0)
    else $error("wormholeArbiter pop to a port without grant");

endmodule

/* logic/switchOutput.sv */
`timescale 1ns/1ps

module switchOutput import routerPkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  grantT                grant,
  flitHeadIf.muxSide           heads [NUM_PORTS],
  input  logic                 outReady,
  output logic                 slotFree,
  output logic                 outValid,
  output flitT                 outFlit,
  output logic [PORT_BITS-1:0] outSrc
);

  flitT                 headFlit [NUM_PORTS];
  flitT                 sel;
  logic [PORT_BITS-1:0] srcIdx;
  logic                 load;

  for (genvar k = 0; k < NUM_PORTS; k++)
  begin : gHead
    assign headFlit[k] = heads[k].head;
  end

  always_comb
  begin
    sel = '0;
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      if (grant[i])
        sel = headFlit[i];
    end
  end

  always_comb
  begin
    case (grant)
      grantT'(1) << PORT_L: srcIdx = PORT_L;
      grantT'(1) << PORT_N: srcIdx = PORT_N;
      grantT'(1) << PORT_E: srcIdx = PORT_E;
      grantT'(1) << PORT_W: srcIdx = PORT_W;
      grantT'(1) << PORT_S: srcIdx = PORT_S;
      default:              srcIdx = '0;
    endcase
  end

  assign slotFree = !outValid || outReady;
  assign load = slotFree && (|grant) && (sel.flitId != '0); // Matches the arbiter pop

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else if (load)
      outValid <= 1'b1;
    else if (outReady)
      outValid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      outFlit <= sel;
      outSrc <= srcIdx;
    end
  end

  // Stalled output holds its flit and source
  assert property (@(posedge clk) disable iff (rst)
      outValid && !outReady |=> outValid && $stable(outFlit) && $stable(outSrc))
    else $error("switchOutput changed while stalled");

endmodule

/* logic/routerOutPort.sv */
`timescale 1ns/1ps

module routerOutPort import routerPkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [NUM_PORTS-1:0] inValid,
  input  flitT                 inFlit [NUM_PORTS],
  output logic [NUM_PORTS-1:0] inFull,
  output logic                 outValid,
  output flitT                 outFlit,
  output logic [PORT_BITS-1:0] outSrc,
  input  logic                 outReady
);

  flitHeadIf headBus [NUM_PORTS] ();

  grantT grant;
  logic  slotFree;

  // One input buffer per port in the order L, N, E, W, S
  for (genvar k = 0; k < NUM_PORTS; k++)
  begin : gFifo
    flitFifo uFifo (
      .clk     (clk),
      .rst     (rst),
      .inValid (inValid[k]),
      .inFlit  (inFlit[k]),
      .inFull  (inFull[k]),
      .head    (headBus[k])
    );
  end

  wormholeArbiter uArbiter (
    .clk      (clk),
    .rst      (rst),
    .slotFree (slotFree),
    .heads    (headBus),
    .grant    (grant)
  );

  switchOutput uSwitch (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .heads    (headBus),
    .outReady (outReady),
    .slotFree (slotFree),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outSrc   (outSrc)
  );

endmodule

/* sim/routerOutPortTb.sv */
`timescale 1ns/1ps

module routerOutPortTb import routerPkg::*; ();

  localparam int PKT_TOTAL = 58; // Packets queued over all phases
  localparam int TIMEOUT_CYCLES = PKT_TOTAL * 6 * 20 + 1000;
  localparam int BUF_SIZE = 256;

  logic                 clk;
  logic                 rst;
  logic [NUM_PORTS-1:0] inValid;
  flitT                 inFlit [NUM_PORTS];
  logic [NUM_PORTS-1:0] inFull;
  logic                 outValid;
  flitT                 outFlit;
  logic [PORT_BITS-1:0] outSrc;
  logic                 outReady;

  flitT                 txMem [NUM_PORTS][BUF_SIZE]; // Every flit sent or still to send, per port
  int                   txWr [NUM_PORTS];
  int                   txRd [NUM_PORTS]; // Also the count of flits driven into the DUT
  int                   expRd [NUM_PORTS]; // Count of flits seen on the output
  int                   stopAt [NUM_PORTS]; // Driving pauses at this index
  logic [NUM_PORTS-1:0] sawFull;
  int                   readyMode; // 0 stalled, 1 always ready, 2 random gaps
  logic                 gateIn;
  logic                 checkOrder;
  int                   lastSrc;
  int                   errors;
  int                   delivered;

  routerOutPort uut (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inFlit   (inFlit),
    .inFull   (inFull),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outSrc   (outSrc),
    .outReady (outReady)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Rotation rule: first pending port after the one served last
  function automatic int nextPort(input logic [NUM_PORTS-1:0] pending, input int last);
    int idx;
    for (int i = 1; i <= NUM_PORTS; i++)
    begin
      idx = (last + i) % NUM_PORTS;
      if (pending[idx])
        return idx;
    end
    return -1;
  endfunction

  function automatic logic [NUM_PORTS-1:0] pendingPorts();
    logic [NUM_PORTS-1:0] mask;
    for (int k = 0; k < NUM_PORTS; k++)
      mask[k] = (expRd[k] < txRd[k]);
    return mask;
  endfunction

  function automatic logic drained();
    for (int k = 0; k < NUM_PORTS; k++)
    begin
      if (txRd[k] != txWr[k] || expRd[k] != txRd[k])
        return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp)
    begin
      errors++;
      $display("FAIL %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
    end
  endtask

  task automatic queuePacket(input int port, input int len);
    flitT f;
    for (int i = 0; i < len; i++)
    begin
      f.flitId = (i == 0) ? FLIT_HEAD : (i == len - 1) ? FLIT_TAIL : FLIT_BODY;
      f.data = DATA_BITS'($urandom);
      if (i == 0)
        f.data[LEN_BITS-1:0] = LEN_BITS'(len); // Length counts the header too
      txMem[port][txWr[port]] = f;
      txWr[port]++;
    end
  endtask

  task automatic waitLoaded();
    while (txRd != txWr)
      @(posedge clk);
    repeat (4) @(posedge clk);
  endtask

  task automatic waitDrained();
    while (!drained())
      @(posedge clk);
    repeat (4) @(posedge clk);
  endtask

  // Input driver, decides at the falling edge and drives at the rising edge
  initial
  begin
    logic [NUM_PORTS-1:0] sendNow;
    forever
    begin
      @(negedge clk);
      for (int k = 0; k < NUM_PORTS; k++)
      begin
        sawFull[k] = sawFull[k] | inFull[k];
        sendNow[k] = !rst && txRd[k] < txWr[k] && txRd[k] != stopAt[k] && !inFull[k]
                     && (txRd[k] - expRd[k] < FIFO_DEPTH) && (!gateIn || $urandom % 4 != 0);
      end
      @(posedge clk);
      for (int k = 0; k < NUM_PORTS; k++)
      begin
        inValid[k] <= sendNow[k];
        if (sendNow[k])
        begin
          inFlit[k] <= txMem[k][txRd[k]];
          txRd[k]++;
        end
      end
      outReady <= (readyMode == 1) || (readyMode == 2 && $urandom % 3 != 0);
    end
  end

  // Output monitor with the packet and stall checks
  initial
  begin
    flitT       stallFlit;
    logic [2:0] stallSrc;
    logic       stalled;
    logic [2:0] expId;
    int         src;
    int         remaining;
    int         curSrc;
    stalled = 1'b0;
    remaining = 0;
    curSrc = 0;
    forever
    begin
      @(negedge clk);
      if (stalled)
      begin
        checkEq(outValid, 1, "outValid dropped while stalled");
        checkEq(outFlit, stallFlit, "outFlit changed while stalled");
        checkEq(outSrc, stallSrc, "outSrc changed while stalled");
      end
      stalled = !rst && outValid && !outReady;
      stallFlit = outFlit;
      stallSrc = outSrc;
      if (!rst && outValid && outReady && outSrc >= NUM_PORTS)
      begin
        errors++;
        $display("A flit was delivered from port %0d, which does not exist", outSrc);
      end
      if (!rst && outValid && outReady && outSrc < NUM_PORTS)
      begin
        src = outSrc;
        if (remaining == 0)
        begin
          if (checkOrder)
            checkEq(src, nextPort(pendingPorts(), lastSrc), "rotation order");
          curSrc = src;
          lastSrc = src;
          remaining = (outFlit.data[LEN_BITS-1:0] == 0) ? 1 : outFlit.data[LEN_BITS-1:0];
          expId = FLIT_HEAD;
        end
        else
        begin
          checkEq(src, curSrc, "flit of another port inside a packet");
          expId = (remaining == 1) ? FLIT_TAIL : FLIT_BODY;
        end
        remaining--;
        checkEq(outFlit.flitId, expId, "flit ID against header length");
        if (expRd[src] < txRd[src])
        begin
          checkEq(outFlit, txMem[src][expRd[src]], "flit from port");
          expRd[src]++;
        end
        else
        begin
          errors++;
          $display("Port %0d delivered a flit that was never sent", src);
        end
        delivered++;
      end
    end
  end

  initial
  begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: flits still pending after %0d cycles", TIMEOUT_CYCLES);
    $display("tests failed");
    $finish;
  end

  initial
  begin
    logic [NUM_PORTS-1:0] stallPorts;
    int                   served;
    void'($urandom(32'h98bb3e04));
    rst = 1'b1;
    inValid = '0;
    outReady = 1'b0;
    for (int k = 0; k < NUM_PORTS; k++)
    begin
      inFlit[k] = '0;
      txWr[k] = 0;
      txRd[k] = 0;
      expRd[k] = 0;
      stopAt[k] = -1;
    end
    sawFull = '0;
    readyMode = 0;
    gateIn = 1'b0;
    checkOrder = 1'b1;
    lastSrc = PORT_S; // Search after reset starts at Local
    errors = 0;
    delivered = 0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    for (int k = 0; k < NUM_PORTS; k++)
      queuePacket(k, 1 + $urandom % 6);
    waitLoaded();
    readyMode = 1;
    waitDrained();
    queuePacket(PORT_N, 1 + $urandom % 6);
    waitDrained();
    readyMode = 0;
    queuePacket(PORT_S, 1 + $urandom % 6);
    queuePacket(PORT_L, 1 + $urandom % 6);
    queuePacket(PORT_E, 1 + $urandom % 6);
    waitLoaded();
    readyMode = 1; // Expected order is E, S, L
    waitDrained();
    checkOrder = 1'b0;

    for (int k = 0; k < NUM_PORTS; k++)
    begin
      for (int p = 0; p < 2; p++)
      begin
        queuePacket(k, 1 + $urandom % 6);
        waitDrained();
      end
    end

    readyMode = 2;
    gateIn = 1'b1;
    for (int p = 0; p < 6; p++)
    begin
      for (int k = 0; k < NUM_PORTS; k++)
        queuePacket(k, 1 + $urandom % 6);
    end
    waitDrained();
    gateIn = 1'b0;

    readyMode = 0;
    sawFull = '0;
    stallPorts = (NUM_PORTS'(1) << PORT_E) | (NUM_PORTS'(1) << PORT_W);
    for (int p = 0; p < 2; p++)
    begin
      queuePacket(PORT_E, 6);
      queuePacket(PORT_W, 6);
    end
    repeat (40) @(posedge clk);
    @(negedge clk);
    checkEq(|sawFull, 1, "inFull never rose with the output stalled");
    // The port served first parks one flit in the output register, the other fills its FIFO
    served = nextPort(stallPorts, lastSrc);
    checkEq(txRd[PORT_E] - expRd[PORT_E], FIFO_DEPTH, "flits taken by port E while stalled");
    checkEq(txRd[PORT_W] - expRd[PORT_W], FIFO_DEPTH, "flits taken by port W while stalled");
    checkEq(inFull, stallPorts & ~(NUM_PORTS'(1) << served), "inFull with a stalled output");
    readyMode = 1;
    waitDrained();

    // Header alone first, the other ports must wait for its tail
    stopAt[PORT_N] = txWr[PORT_N] + 1;
    queuePacket(PORT_N, 6);
    repeat (20) @(posedge clk);
    for (int k = 0; k < NUM_PORTS; k++)
    begin
      if (k != PORT_N)
        queuePacket(k, 1 + $urandom % 6);
    end
    repeat (30) @(posedge clk);
    stopAt[PORT_N] = -1;
    waitDrained();

    $display("Run complete with %0d errors over %0d flits", errors, delivered);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

/* src.f */
logic/routerPkg.sv
logic/flitHeadIf.sv
logic/flitFifo.sv
logic/wormholeArbiter.sv
logic/switchOutput.sv
logic/routerOutPort.sv
sim/routerOutPortTb.sv
